//--- design/xbar_settings.svh
`ifndef XBAR_SETTINGS_SVH
`define XBAR_SETTINGS_SVH

////////////////////
// Crossbar sizing
////////////////////

// Masters on the request side
`define XBAR_N_MASTER 4

// Slaves on the memory side, power of two only
`define XBAR_N_SLAVE 4

////////////////////
// Bus widths
////////////////////

`define XBAR_ADDR_WIDTH 32 // Full address reaches the slaves
`define XBAR_DATA_WIDTH 32
`define XBAR_BE_WIDTH   4  // One enable per data byte

// Slave select field, bits 11:10
`define XBAR_ROUTE_LSB   10
`define XBAR_ROUTE_WIDTH 2 // log2 of slave count

`endif

//--- design/xbar_pkg.sv
`default_nettype none

`include "xbar_settings.svh"

package xbar_pkg;

    ////////////////////
    // Payload types
    ////////////////////

    typedef logic [`XBAR_ADDR_WIDTH-1:0]  addr_t;      // Request address
    typedef logic [`XBAR_DATA_WIDTH-1:0]  data_t;      // Write or read data
    typedef logic [`XBAR_BE_WIDTH-1:0]    be_t;        // Byte enables
    typedef logic [`XBAR_N_MASTER-1:0]    master_id_t; // One-hot, bit per master
    typedef logic [`XBAR_ROUTE_WIDTH-1:0] slave_sel_t; // Slave index

    // Request type, same meaning as the wen pin
    typedef enum logic {
        OP_STORE = 1'b0,
        OP_LOAD  = 1'b1
    } req_op_e;

    // Response status
    typedef enum logic {
        RESP_OK  = 1'b0,
        RESP_ERR = 1'b1
    } resp_opc_e;

    // One routed request, tagged with its master
    typedef struct packed {
        addr_t      add;   // Full address
        req_op_e    wen;   // Store or load
        data_t      wdata; // Store data
        be_t        be;
        master_id_t id;    // Used to steer the response back
    } master_req_t;

endpackage

`default_nettype wire

//--- design/xbar_req_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "xbar_settings.svh"

// Request fabric between the master decoders and the slave arbiters
interface xbar_req_if;

    // Payload of each master, already tagged with its one-hot ID
    xbar_pkg::master_req_t        req_payload [`XBAR_N_MASTER];

    // Bit s set while master m requests slave s
    logic [`XBAR_N_SLAVE-1:0]     req_route   [`XBAR_N_MASTER];

    // Bit s set when slave s accepts master m
    logic [`XBAR_N_SLAVE-1:0]     gnt_route   [`XBAR_N_MASTER];

    ////////////////////
    // Views
    ////////////////////

    // Master side, one row per decoder
    modport decoder (
        output req_payload,
        output req_route,
        input  gnt_route
    );

    // Slave side, one column per arbiter
    modport arbiter (
        input  req_payload,
        input  req_route,
        output gnt_route
    );

endinterface

`default_nettype wire

//--- design/route_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "xbar_settings.svh"

// Master-side address decode and grant collection
module route_decoder #(
    parameter int MASTER_IDX = 0 // Row of this master in the request fabric
) (
    input  logic                   data_req_i,   // Request valid
    input  xbar_pkg::addr_t        data_add_i,
    input  xbar_pkg::req_op_e      data_wen_i,   // Store or load
    input  xbar_pkg::data_t        data_wdata_i,
    input  xbar_pkg::be_t          data_be_i,
    output logic                   data_gnt_o,   // Ready back to master
    output logic                   grant_o,      // Request accepted this cycle
    output xbar_pkg::slave_sel_t   slave_sel_o,  // Target slave, for the response side
    xbar_req_if.decoder            req_bus
);

    // One-hot tag for this master
    localparam xbar_pkg::master_id_t MY_ID = xbar_pkg::master_id_t'(1) << MASTER_IDX;
    localparam logic [`XBAR_N_SLAVE-1:0] ROUTE_ONE = 1;

    xbar_pkg::slave_sel_t  route_sel; // Decoded slave index
    xbar_pkg::master_req_t payload;

    ////////////////////
    // Decode
    ////////////////////

    // Slave select field of the address
    assign route_sel   = data_add_i[`XBAR_ROUTE_LSB +: `XBAR_ROUTE_WIDTH];
    assign slave_sel_o = route_sel;

    // Raise only the target column, and only while requesting
    assign req_bus.req_route[MASTER_IDX] = data_req_i ? (ROUTE_ONE << route_sel) : '0;

    // Payload bundle with ID attached
    always_comb
    begin
        payload.add   = data_add_i;
        payload.wen   = data_wen_i;
        payload.wdata = data_wdata_i;
        payload.be    = data_be_i;
        payload.id    = MY_ID;
    end

    assign req_bus.req_payload[MASTER_IDX] = payload;

    ////////////////////
    // Grant
    ////////////////////

    // At most one slave can grant, since only one column is requested
    assign data_gnt_o = |req_bus.gnt_route[MASTER_IDX];
    assign grant_o    = data_req_i & data_gnt_o; // Handshake done

endmodule

`default_nettype wire

//--- design/slave_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "xbar_settings.svh"

// Round-robin arbiter in front of one slave port
module slave_arbiter #(
    parameter int SLAVE_IDX = 0 // Column of this slave in the request fabric
) (
    input  logic                          clk,
    input  logic                          rst_n_i,
    xbar_req_if.arbiter                   req_bus,
    // Slave request
    output logic                          data_req_o,
    output xbar_pkg::addr_t               data_add_o,
    output xbar_pkg::req_op_e             data_wen_o,
    output xbar_pkg::data_t               data_wdata_o,
    output xbar_pkg::be_t                 data_be_o,
    output xbar_pkg::master_id_t          data_id_o,
    input  logic                          data_gnt_i,     // Slave ready
    // Slave response
    input  logic                          data_r_valid_i,
    input  xbar_pkg::master_id_t          data_r_id_i,    // Echo of the accepted ID
    output logic [`XBAR_N_MASTER-1:0]     r_valid_o       // Response valid per master
);

    localparam int NM    = `XBAR_N_MASTER;
    localparam int PTR_W = (NM > 1) ? $clog2(NM) : 1;

    logic [NM-1:0]         req_vec;  // Masters aiming at this slave
    logic [NM-1:0]         gnt_vec;  // Grant per master
    logic [PTR_W-1:0]      rr_ptr_q; // Highest-priority master
    logic [PTR_W-1:0]      winner;
    logic                  accept;   // Slave handshake done
    xbar_pkg::master_req_t win_req;

    ////////////////////
    // Request collection
    ////////////////////

    for (genvar m = 0; m < NM; m++)
    begin : g_col
        assign req_vec[m] = req_bus.req_route[m][SLAVE_IDX];
        assign req_bus.gnt_route[m][SLAVE_IDX] = gnt_vec[m]; // Own bit only
    end

    // First requester at or after the pointer, scanned backwards so the
    // nearest one is written last
    always_comb
    begin : rr_pick
        int unsigned cand;
        cand   = 0;
        winner = rr_ptr_q;
        for (int off = NM - 1; off >= 0; off--)
        begin
            cand = (int'(rr_ptr_q) + off) % NM;
            if (req_vec[cand])
            begin
                winner = PTR_W'(cand);
            end
        end
    end

    assign data_req_o = |req_vec;
    assign accept     = data_req_o & data_gnt_i;
    assign gnt_vec    = accept ? (NM'(1) << winner) : '0; // Combinational grant

    // Forward winning payload
    assign win_req      = req_bus.req_payload[winner];
    assign data_add_o   = win_req.add;
    assign data_wen_o   = win_req.wen;
    assign data_wdata_o = win_req.wdata;
    assign data_be_o    = win_req.be;
    assign data_id_o    = win_req.id;

    // Pointer moves past the winner after each acceptance
    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            rr_ptr_q <= '0; // Start at master 0
        end
        else if (accept)
        begin
            rr_ptr_q <= PTR_W'((int'(winner) + 1) % NM);
        end
    end

    ////////////////////
    // Response fan-out
    ////////////////////

    assign r_valid_o = data_r_valid_i ? data_r_id_i : '0; // ID is already one-hot

    // Grant goes to the one master whose tagged payload reaches the slave
    a_one_grant : assert property (@(posedge clk) disable iff (!rst_n_i)
        accept |-> (data_id_o == gnt_vec));

    // Slave must echo a proper one-hot ID
    a_id_onehot : assert property (@(posedge clk) disable iff (!rst_n_i)
        data_r_valid_i |-> $onehot(data_r_id_i));

endmodule

`default_nettype wire

//--- design/resp_router.sv
`timescale 1ns/1ps
`default_nettype none

`include "xbar_settings.svh"

// Per-master response mux
module resp_router (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       grant_i,       // Request accepted this cycle
    input  xbar_pkg::slave_sel_t       slave_sel_i,   // Slave that accepted it
    input  logic [`XBAR_N_SLAVE-1:0]   r_valid_i,     // Valid from each slave
    input  xbar_pkg::data_t            data_r_rdata_i [`XBAR_N_SLAVE],
    input  xbar_pkg::resp_opc_e        data_r_opc_i   [`XBAR_N_SLAVE],
    output logic                       data_r_valid_o,
    output xbar_pkg::data_t            data_r_rdata_o,
    output xbar_pkg::resp_opc_e        data_r_opc_o
);

    localparam logic [`XBAR_N_SLAVE-1:0] SEL_ONE = 1;

    xbar_pkg::slave_sel_t sel_q; // Slave holding the in-flight request

    ////////////////////
    // Slave tracking
    ////////////////////

    // Captured at the grant edge, used one cycle later
    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            sel_q <= '0;
        end
        else if (grant_i)
        begin
            sel_q <= slave_sel_i; // New request overwrites, old one has returned
        end
    end

    ////////////////////
    // Return path
    ////////////////////

    // Only one slave can carry this master's ID
    assign data_r_valid_o = |r_valid_i;

    // Mux from the stored index
    assign data_r_rdata_o = data_r_rdata_i[sel_q];
    assign data_r_opc_o   = data_r_opc_i[sel_q];

    // Response comes from the slave granted one cycle before
    a_resp_src : assert property (@(posedge clk) disable iff (!rst_n_i)
        (|r_valid_i) |-> ((r_valid_i == (SEL_ONE << sel_q)) && $past(grant_i)));

endmodule

`default_nettype wire

//--- design/periph_xbar.sv
`timescale 1ns/1ps
`default_nettype none

`include "xbar_settings.svh"

// Peripheral crossbar, masters to slaves by address bits 11:10
module periph_xbar (
    input  logic                                              clk,
    input  logic                                              rst_n_i,
    // Master side request
    input  logic [`XBAR_N_MASTER-1:0]                         data_req_i,
    input  logic [`XBAR_N_MASTER-1:0][`XBAR_ADDR_WIDTH-1:0]   data_add_i,
    input  logic [`XBAR_N_MASTER-1:0]                         data_wen_i,   // 0 store, 1 load
    input  logic [`XBAR_N_MASTER-1:0][`XBAR_DATA_WIDTH-1:0]   data_wdata_i,
    input  logic [`XBAR_N_MASTER-1:0][`XBAR_BE_WIDTH-1:0]     data_be_i,
    output logic [`XBAR_N_MASTER-1:0]                         data_gnt_o,
    // Master side response
    output logic [`XBAR_N_MASTER-1:0]                         data_r_valid_o,
    output logic [`XBAR_N_MASTER-1:0][`XBAR_DATA_WIDTH-1:0]   data_r_rdata_o,
    output logic [`XBAR_N_MASTER-1:0]                         data_r_opc_o, // 1 on error
    // Slave side request
    output logic [`XBAR_N_SLAVE-1:0]                          data_req_o,
    output logic [`XBAR_N_SLAVE-1:0][`XBAR_ADDR_WIDTH-1:0]    data_add_o,
    output logic [`XBAR_N_SLAVE-1:0]                          data_wen_o,
    output logic [`XBAR_N_SLAVE-1:0][`XBAR_DATA_WIDTH-1:0]    data_wdata_o,
    output logic [`XBAR_N_SLAVE-1:0][`XBAR_BE_WIDTH-1:0]      data_be_o,
    output logic [`XBAR_N_SLAVE-1:0][`XBAR_N_MASTER-1:0]      data_id_o,
    input  logic [`XBAR_N_SLAVE-1:0]                          data_gnt_i,
    // Slave side response
    input  logic [`XBAR_N_SLAVE-1:0]                          data_r_valid_i,
    input  logic [`XBAR_N_SLAVE-1:0][`XBAR_N_MASTER-1:0]      data_r_id_i,
    input  logic [`XBAR_N_SLAVE-1:0][`XBAR_DATA_WIDTH-1:0]    data_r_rdata_i,
    input  logic [`XBAR_N_SLAVE-1:0]                          data_r_opc_i
);

    xbar_req_if req_bus (); // Request fabric

    logic                      mst_grant     [`XBAR_N_MASTER]; // Accepted this cycle
    xbar_pkg::slave_sel_t      mst_slave_sel [`XBAR_N_MASTER];
    logic [`XBAR_N_SLAVE-1:0]  mst_r_valid   [`XBAR_N_MASTER]; // Indexed by slave
    logic [`XBAR_N_MASTER-1:0] slv_r_valid   [`XBAR_N_SLAVE];  // Indexed by master
    xbar_pkg::data_t           slv_rdata     [`XBAR_N_SLAVE];
    xbar_pkg::resp_opc_e       slv_opc       [`XBAR_N_SLAVE];

    ////////////////////
    // Response wiring
    ////////////////////

    for (genvar s = 0; s < `XBAR_N_SLAVE; s++)
    begin : g_slv_resp
        assign slv_rdata[s] = data_r_rdata_i[s];
        assign slv_opc[s]   = xbar_pkg::resp_opc_e'(data_r_opc_i[s]);
        for (genvar m = 0; m < `XBAR_N_MASTER; m++)
        begin : g_tr
            assign mst_r_valid[m][s] = slv_r_valid[s][m]; // Transpose
        end
    end

    ////////////////////
    // Master side
    ////////////////////

    for (genvar m = 0; m < `XBAR_N_MASTER; m++)
    begin : g_mst
        route_decoder #(.MASTER_IDX(m)) route_decoder_i (
            .data_req_i   (data_req_i[m]),
            .data_add_i   (data_add_i[m]),
            .data_wen_i   (xbar_pkg::req_op_e'(data_wen_i[m])),
            .data_wdata_i (data_wdata_i[m]),
            .data_be_i    (data_be_i[m]),
            .data_gnt_o   (data_gnt_o[m]),
            .grant_o      (mst_grant[m]),
            .slave_sel_o  (mst_slave_sel[m]),
            .req_bus      (req_bus.decoder)
        );

        resp_router resp_router_i (
            .clk            (clk),
            .rst_n_i        (rst_n_i),
            .grant_i        (mst_grant[m]),
            .slave_sel_i    (mst_slave_sel[m]),
            .r_valid_i      (mst_r_valid[m]),
            .data_r_rdata_i (slv_rdata),
            .data_r_opc_i   (slv_opc),
            .data_r_valid_o (data_r_valid_o[m]),
            .data_r_rdata_o (data_r_rdata_o[m]),
            .data_r_opc_o   (data_r_opc_o[m])
        );
    end

    ////////////////////
    // Slave side
    ////////////////////

    for (genvar s = 0; s < `XBAR_N_SLAVE; s++)
    begin : g_slv
        slave_arbiter #(.SLAVE_IDX(s)) slave_arbiter_i (
            .clk            (clk),
            .rst_n_i        (rst_n_i),
            .req_bus        (req_bus.arbiter),
            .data_req_o     (data_req_o[s]),
            .data_add_o     (data_add_o[s]),
            .data_wen_o     (data_wen_o[s]),
            .data_wdata_o   (data_wdata_o[s]),
            .data_be_o      (data_be_o[s]),
            .data_id_o      (data_id_o[s]),
            .data_gnt_i     (data_gnt_i[s]),
            .data_r_valid_i (data_r_valid_i[s]),
            .data_r_id_i    (data_r_id_i[s]),
            .r_valid_o      (slv_r_valid[s])
        );
    end

endmodule

`default_nettype wire

//--- verif/tb_periph_xbar.sv
`timescale 1ns/1ps
`default_nettype none

`include "xbar_settings.svh"

module tb_periph_xbar;

    localparam int NM         = `XBAR_N_MASTER;
    localparam int NS         = `XBAR_N_SLAVE;
    localparam int CLK_PERIOD = 4;
    localparam int MAX_WAIT   = 16; // Grant wait limit per access
    // Cycles per test: reset, routing, response, round robin, parallel, back-pressure
    localparam int RUN_CYCLES = 4 + 20 + 10 + 15 + 10 + 15;

    logic                                       clk;
    logic                                       rst_n_i;
    logic [NM-1:0]                              data_req_i;
    logic [NM-1:0][`XBAR_ADDR_WIDTH-1:0]        data_add_i;
    logic [NM-1:0]                              data_wen_i;
    logic [NM-1:0][`XBAR_DATA_WIDTH-1:0]        data_wdata_i;
    logic [NM-1:0][`XBAR_BE_WIDTH-1:0]          data_be_i;
    logic [NM-1:0]                              data_gnt_o;
    logic [NM-1:0]                              data_r_valid_o;
    logic [NM-1:0][`XBAR_DATA_WIDTH-1:0]        data_r_rdata_o;
    logic [NM-1:0]                              data_r_opc_o;
    logic [NS-1:0]                              data_req_o;
    logic [NS-1:0][`XBAR_ADDR_WIDTH-1:0]        data_add_o;
    logic [NS-1:0]                              data_wen_o;
    logic [NS-1:0][`XBAR_DATA_WIDTH-1:0]        data_wdata_o;
    logic [NS-1:0][`XBAR_BE_WIDTH-1:0]          data_be_o;
    logic [NS-1:0][NM-1:0]                      data_id_o;
    logic [NS-1:0]                              data_gnt_i;
    logic [NS-1:0]                              data_r_valid_i;
    logic [NS-1:0][NM-1:0]                      data_r_id_i;
    logic [NS-1:0][`XBAR_DATA_WIDTH-1:0]        data_r_rdata_i;
    logic [NS-1:0]                              data_r_opc_i;

    logic [NS-1:0] slv_en;            // Grant enable per slave model
    integer        seed = 32'h9e1c_fdb8;
    int            err_cnt;
    int            err_mark;          // Error count at test start
    int            pass_cnt;
    int            fail_cnt;

    assign data_gnt_i = slv_en;

    periph_xbar periph_xbar_i (.*);

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////
    // Slave models
    ////////////////////

    // Sample mid-cycle, answer right after the next edge
    initial
    begin : slave_models
        logic [NS-1:0]        acc;
        xbar_pkg::master_id_t cap_id  [NS];
        xbar_pkg::addr_t      cap_add [NS];
        data_r_valid_i = '0;
        data_r_id_i    = '0;
        data_r_rdata_i = '0;
        data_r_opc_i   = '0;
        forever
        begin
            @(negedge clk);
            for (int s = 0; s < NS; s++)
            begin
                acc[s]     = data_req_o[s] & data_gnt_i[s]; // Accepted this cycle
                cap_id[s]  = data_id_o[s];
                cap_add[s] = data_add_o[s];
            end
            @(posedge clk);
            #1;
            for (int s = 0; s < NS; s++)
            begin
                data_r_valid_i[s] = acc[s];
                data_r_id_i[s]    = acc[s] ? cap_id[s] : '0;
                data_r_rdata_i[s] = cap_add[s] ^ (xbar_pkg::data_t'(s) << 24); // Index in top byte
                data_r_opc_i[s]   = cap_add[s][0]; // Odd address is an error
            end
        end
    end

    ////////////////////
    // Compare tasks
    ////////////////////

    task automatic check_data(input string what, input xbar_pkg::data_t got,
                              input xbar_pkg::data_t exp);
        if (got !== exp)
        begin
            err_cnt++;
            $display("error %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_opc(input string what, input xbar_pkg::resp_opc_e got,
                             input xbar_pkg::resp_opc_e exp);
        if (got !== exp)
        begin
            err_cnt++;
            $display("error %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_id(input string what, input xbar_pkg::master_id_t got,
                            input xbar_pkg::master_id_t exp);
        if (got !== exp)
        begin
            err_cnt++;
            $display("error %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // Grant, valid and select vectors, byte enables, opcode
    task automatic check_bits(input string what, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp)
        begin
            err_cnt++;
            $display("error %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    ////////////////////
    // Expected values
    ////////////////////

    // Slave index comes from address bits 11:10
    function automatic xbar_pkg::data_t exp_rdata(input xbar_pkg::addr_t addr);
        xbar_pkg::slave_sel_t sel;
        sel = addr[`XBAR_ROUTE_LSB +: `XBAR_ROUTE_WIDTH];
        return addr ^ (xbar_pkg::data_t'(sel) << 24);
    endfunction

    function automatic xbar_pkg::resp_opc_e exp_opc(input xbar_pkg::addr_t addr);
        return addr[0] ? xbar_pkg::RESP_ERR : xbar_pkg::RESP_OK;
    endfunction

    ////////////////////
    // Drivers
    ////////////////////

    task automatic apply_reset;
        rst_n_i = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
    endtask

    // Called 1 ns after a rising edge
    task automatic issue_req(input int m, input xbar_pkg::addr_t addr,
                             input xbar_pkg::req_op_e op, input xbar_pkg::data_t wdata,
                             input xbar_pkg::be_t be);
        data_req_i[m]   = 1'b1;
        data_add_i[m]   = addr;
        data_wen_i[m]   = op;
        data_wdata_i[m] = wdata;
        data_be_i[m]    = be;
    endtask

    task automatic wait_grant(input int m, output bit ok);
        int n;
        ok = 1'b0;
        n  = 0;
        while (!ok && n < MAX_WAIT)
        begin
            @(negedge clk);
            ok = data_gnt_o[m];
            n++;
        end
        if (!ok)
        begin
            err_cnt++;
            $display("master %0d saw no grant within %0d cycles", m, MAX_WAIT);
        end
    endtask

    // Grant, slave port contents, then the response one cycle later
    task automatic finish_access(input int m);
        bit                   ok;
        xbar_pkg::addr_t      addr;
        xbar_pkg::slave_sel_t sel;
        addr = data_add_i[m];
        sel  = addr[`XBAR_ROUTE_LSB +: `XBAR_ROUTE_WIDTH];
        wait_grant(m, ok);
        if (ok)
        begin
            check_bits("slave request", 8'(data_req_o), 8'(1) << sel);
            check_data("slave address", data_add_o[sel], addr);
            check_data("slave write data", data_wdata_o[sel], data_wdata_i[m]);
            check_bits("slave byte enables", 8'(data_be_o[sel]), 8'(data_be_i[m]));
            check_bits("slave opcode", 8'(data_wen_o[sel]), 8'(data_wen_i[m]));
            check_id("slave id", data_id_o[sel], xbar_pkg::master_id_t'(1) << m);
        end
        @(posedge clk);
        #1;
        data_req_i[m] = 1'b0;
        @(negedge clk);
        check_bits("response valid", 8'(data_r_valid_o), 8'(1) << m);
        check_data("read data", data_r_rdata_o[m], exp_rdata(addr));
        check_opc("response status", xbar_pkg::resp_opc_e'(data_r_opc_o[m]), exp_opc(addr));
    endtask

    task automatic end_test(input string name);
        if (err_cnt == err_mark)
        begin
            pass_cnt++;
            $display("%s: ok", name);
        end
        else
        begin
            fail_cnt++;
            $display("%s: %0d errors", name, err_cnt - err_mark);
        end
        err_mark = err_cnt;
    endtask

    ////////////////////
    // Tests
    ////////////////////

    // One master at a time, each to a different slave
    task automatic test_routing;
        xbar_pkg::addr_t addr;
        @(negedge clk);
        check_bits("idle grants", 8'(data_gnt_o), 8'h0); // Quiet after reset
        check_bits("idle slave requests", 8'(data_req_o), 8'h0);
        for (int m = 0; m < NM; m++)
        begin
            addr = $random(seed);
            addr[0] = 1'b0;
            addr[`XBAR_ROUTE_LSB +: `XBAR_ROUTE_WIDTH] = NS - 1 - m;
            @(posedge clk);
            #1;
            issue_req(m, addr, (m % 2) ? xbar_pkg::OP_LOAD : xbar_pkg::OP_STORE,
                      $random(seed), xbar_pkg::be_t'($random(seed)));
            finish_access(m);
        end
        end_test("routing");
    endtask

    task automatic test_response;
        @(posedge clk);
        #1;
        issue_req(2, 32'h0000_0c40, xbar_pkg::OP_LOAD, '0, 4'hf);
        finish_access(2);
        @(posedge clk);
        #1;
        issue_req(2, 32'h0000_0403, xbar_pkg::OP_LOAD, '0, 4'hf); // Odd, error status
        finish_access(2);
        end_test("response return");
    endtask

    // All masters on slave 1 from reset
    task automatic test_round_robin;
        xbar_pkg::addr_t cur [NM];
        xbar_pkg::addr_t prev_addr;
        int              exp_m;
        int              prev_m;
        @(posedge clk);
        #1;
        apply_reset;
        for (int m = 0; m < NM; m++)
        begin
            cur[m] = 32'h0000_0400 | (m << 4);
            issue_req(m, cur[m], xbar_pkg::OP_LOAD, '0, 4'hf);
        end
        prev_m    = 0;
        prev_addr = '0;
        for (int k = 0; k <= 5; k++)
        begin
            @(negedge clk);
            if (k > 0)
            begin
                check_bits("rr response valid", 8'(data_r_valid_o), 8'(1) << prev_m);
                check_data("rr read data", data_r_rdata_o[prev_m], exp_rdata(prev_addr));
            end
            if (k < 5)
            begin
                exp_m = k % NM; // Expected order 0 1 2 3 0
                check_bits("rr grant", 8'(data_gnt_o), 8'(1) << exp_m);
                prev_m    = exp_m;
                prev_addr = cur[exp_m];
                @(posedge clk);
                #1;
                cur[exp_m]        = cur[exp_m] + 32'h100; // Same slave, next word
                data_add_i[exp_m] = cur[exp_m];
                if (k == 4)
                    data_req_i = '0;
            end
        end
        end_test("round robin");
    endtask

    task automatic test_parallel;
        xbar_pkg::addr_t addr [NM];
        @(posedge clk);
        #1;
        for (int m = 0; m < NM; m++)
        begin
            addr[m] = (32'(m) << 28) | (32'((m + 1) % NS) << 10) | 32'(m << 2);
            issue_req(m, addr[m], xbar_pkg::OP_LOAD, '0, 4'hf);
        end
        @(negedge clk);
        check_bits("parallel grants", 8'(data_gnt_o), 8'((1 << NM) - 1));
        check_bits("parallel slave requests", 8'(data_req_o), 8'((1 << NS) - 1));
        @(posedge clk);
        #1;
        data_req_i = '0;
        @(negedge clk);
        check_bits("parallel response valid", 8'(data_r_valid_o), 8'((1 << NM) - 1));
        for (int m = 0; m < NM; m++)
            check_data("parallel read data", data_r_rdata_o[m], exp_rdata(addr[m]));
        end_test("parallel slaves");
    endtask

    task automatic test_backpressure;
        @(posedge clk);
        #1;
        slv_en[3] = 1'b0; // Slave 3 stalls
        issue_req(1, 32'h0000_0c80, xbar_pkg::OP_STORE, 32'hcafe_f00d, 4'h3);
        repeat (5)
        begin
            @(negedge clk);
            check_bits("held grant", 8'(data_gnt_o[1]), 8'h0);
            check_bits("held response", 8'(data_r_valid_o[1]), 8'h0);
        end
        @(posedge clk);
        #1;
        slv_en[3] = 1'b1;
        finish_access(1);
        end_test("back-pressure");
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial
    begin
        data_req_i   = '0;
        data_add_i   = '0;
        data_wen_i   = '0;
        data_wdata_i = '0;
        data_be_i    = '0;
        slv_en       = '1;
        err_cnt      = 0;
        err_mark     = 0;
        pass_cnt     = 0;
        fail_cnt     = 0;
        apply_reset;
        test_routing;
        test_response;
        test_round_robin;
        test_parallel;
        test_backpressure;
        $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && err_cnt == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

    // Ends a hung run
    initial
    begin : watchdog
        #(RUN_CYCLES * CLK_PERIOD + 100);
        $display("Run did not finish within its budget of %0d cycles", RUN_CYCLES);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+design
design/xbar_pkg.sv
design/xbar_req_if.sv
design/route_decoder.sv
design/slave_arbiter.sv
design/resp_router.sv
design/periph_xbar.sv
verif/tb_periph_xbar.sv

//--- Makefile
# Verilator build for the peripheral crossbar testbench
# Any variable can be overridden, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= tb_periph_xbar
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass or fail is decided by the log, not by the simulator exit code
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TB PASSED" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
